/* verilog/axis_stream_pkg.sv */
// Stream payload types, imported by every FIFO stage and by the testbench
package axis_stream_pkg;

    // --------------------
    // Beat layout
    // --------------------

    // Data field width, fixed for the whole subsystem
    localparam int DATA_W = 32;

    // One stream beat
    // tdata sits in the upper bits, tlast in bit 0
    typedef struct packed {
        logic [DATA_W-1:0] tdata;
        logic              tlast;
    } axis_beat_t;

endpackage

/* verilog/fifo_cfg_pkg.sv */
// FIFO configuration types: implementation select, FSM states and status counts
package fifo_cfg_pkg;

    // Largest supported SIZE, sets the count width to MAX_SIZE+1
    localparam int MAX_SIZE = 6;

    // --------------------
    // Implementation select
    // --------------------

    // Which FIFO body the wrapper builds
    typedef enum logic [1:0] {
        IMPL_MINIMAL = 2'd0,
        IMPL_SRL     = 2'd1,
        IMPL_RAM     = 2'd2
    } fifo_impl_e;

    // Fill state of the two-entry register FIFO
    typedef enum logic [1:0] {
        MIN_EMPTY = 2'd0,
        MIN_ONE   = 2'd1,
        MIN_FULL  = 2'd2
    } min_state_e;

    // --------------------
    // Status counts
    // --------------------

    // Per stage, space + occupied is always the stage capacity
    typedef struct packed {
        logic [MAX_SIZE:0] space;
        logic [MAX_SIZE:0] occupied;
    } fifo_status_t;

    // Whole chain, input stage first
    typedef struct packed {
        fifo_status_t stage_a;
        fifo_status_t stage_b;
        fifo_status_t stage_c;
    } chain_status_t;

endpackage

/* verilog/axis_minimal_fifo.sv */
// Two-entry register FIFO, built by axis_fifo for SIZE 1 and 2
`timescale 1ns/1ps

module axis_minimal_fifo (
    input  logic                        clk,
    input  logic                        rst_n,
    input  axis_stream_pkg::axis_beat_t in_beat,
    input  logic                        in_valid,
    output logic                        in_ready,
    output axis_stream_pkg::axis_beat_t out_beat,
    output logic                        out_valid,
    input  logic                        out_ready,
    output fifo_cfg_pkg::fifo_status_t  status
);
    import axis_stream_pkg::*;
    import fifo_cfg_pkg::*;

    localparam int CNT_W = MAX_SIZE + 1;

    min_state_e state;
    // Older entry, always the one presented
    axis_beat_t head;
    // Second entry, only used in MIN_FULL
    axis_beat_t tail;
    logic [1:0] fill;
    logic       push;
    logic       pop;

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    // Handshake straight from the state register
    assign in_ready  = (state != MIN_FULL);
    assign out_valid = (state != MIN_EMPTY);
    assign out_beat  = head;

    // --------------------
    // Fill FSM
    // --------------------
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state <= MIN_EMPTY;
        end
        else
        begin
            case (state)
                MIN_EMPTY:
                begin
                    if (push)
                        state <= MIN_ONE;
                end
                MIN_ONE:
                begin
                    // Push and pop together keep one entry
                    if (push && !pop)
                        state <= MIN_FULL;
                    else if (pop && !push)
                        state <= MIN_EMPTY;
                end
                MIN_FULL:
                begin
                    // No push possible here, in_ready is low
                    if (pop)
                        state <= MIN_ONE;
                end
                default:
                begin
                    state <= MIN_EMPTY;
                end
            endcase
        end
    end

    // --------------------
    // Entry registers
    // --------------------
    always_ff @(posedge clk)
    begin
        case (state)
            MIN_EMPTY:
            begin
                if (push)
                    head <= in_beat;
            end
            MIN_ONE:
            begin
                // Head leaves, new beat takes its place
                if (push && pop)
                    head <= in_beat;
                else if (push)
                    tail <= in_beat;
            end
            MIN_FULL:
            begin
                // Promote the younger entry
                if (pop)
                    head <= tail;
            end
            default:
            begin
                head <= head;
            end
        endcase
    end

    // Occupancy falls out of the state
    always_comb
    begin
        case (state)
            MIN_ONE:  fill = 2'd1;
            MIN_FULL: fill = 2'd2;
            default:  fill = 2'd0;
        endcase
        status.occupied = CNT_W'(fill);
        status.space    = CNT_W'(2'd2 - fill);
    end

endmodule

/* verilog/axis_fifo_srl.sv */
// Shift-register FIFO with a registered output, built by axis_fifo for SIZE 3 to 5
`timescale 1ns/1ps

module axis_fifo_srl #(
    parameter int SIZE = 5
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  axis_stream_pkg::axis_beat_t in_beat,
    input  logic                        in_valid,
    output logic                        in_ready,
    output axis_stream_pkg::axis_beat_t out_beat,
    output logic                        out_valid,
    input  logic                        out_ready,
    output fifo_cfg_pkg::fifo_status_t  status
);
    import axis_stream_pkg::*;
    import fifo_cfg_pkg::*;

    // Physical shift length, capacity cut down to 2^SIZE
    localparam int SRL_LEN = 32;
    localparam int DEPTH   = 1 << SIZE;
    localparam int CNT_W   = MAX_SIZE + 1;

    // Newest beat at index 0
    axis_beat_t       srl [SRL_LEN];
    // Beats in the shift array, not counting the output register
    logic [5:0]       srl_cnt;
    // Oldest entry in the array
    logic [4:0]       tail;
    logic [CNT_W-1:0] fill;
    logic             push;
    logic             load_out;
    logic             take_srl;
    logic             shift_in;

    assign push     = in_valid && in_ready;
    assign tail     = 5'(srl_cnt - 6'd1);
    // Output register free on this edge
    assign load_out = !out_valid || out_ready;
    assign take_srl = load_out && (srl_cnt != 6'd0);
    // Bypass the array when it is empty and the output register is free
    assign shift_in = push && !(load_out && (srl_cnt == 6'd0));

    // Total held, output register included
    assign fill     = CNT_W'(srl_cnt) + CNT_W'(out_valid);
    assign in_ready = (fill < CNT_W'(DEPTH));

    // --------------------
    // Shift array
    // --------------------
    always_ff @(posedge clk)
    begin
        if (shift_in)
        begin
            srl[0] <= in_beat;
            for (int i = 1; i < SRL_LEN; i++)
            begin
                srl[i] <= srl[i-1];
            end
        end
    end

    // Array count and output valid
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            srl_cnt   <= 6'd0;
            out_valid <= 1'b0;
        end
        else
        begin
            if (shift_in && !take_srl)
                srl_cnt <= srl_cnt + 6'd1;
            else if (take_srl && !shift_in)
                srl_cnt <= srl_cnt - 6'd1;
            if (load_out)
                out_valid <= take_srl || push;
        end
    end

    // Output payload, oldest array entry first, else the bypassed beat
    always_ff @(posedge clk)
    begin
        if (take_srl)
            out_beat <= srl[tail];
        else if (load_out && push)
            out_beat <= in_beat;
    end

    assign status.occupied = fill;
    assign status.space    = CNT_W'(DEPTH) - fill;

endmodule

/* verilog/axis_fifo_ram.sv */
// RAM-array FIFO with registered read and output holding register, for SIZE above 5
`timescale 1ns/1ps

module axis_fifo_ram #(
    parameter int SIZE = 6
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  axis_stream_pkg::axis_beat_t in_beat,
    input  logic                        in_valid,
    output logic                        in_ready,
    output axis_stream_pkg::axis_beat_t out_beat,
    output logic                        out_valid,
    input  logic                        out_ready,
    output fifo_cfg_pkg::fifo_status_t  status
);
    import axis_stream_pkg::*;
    import fifo_cfg_pkg::*;

    localparam int DEPTH = 1 << SIZE;
    localparam int CNT_W = MAX_SIZE + 1;

    // --------------------
    // Storage and pointers
    // --------------------

    axis_beat_t       mem [DEPTH];
    // One extra bit tells full from empty
    logic [SIZE:0]    wr_ptr;
    logic [SIZE:0]    rd_ptr;
    // Entries still in the array
    logic [SIZE:0]    ram_cnt;
    logic [CNT_W-1:0] fill;
    logic             push;
    // Prefetch into the holding register
    logic             load;

    assign push    = in_valid && in_ready;
    assign ram_cnt = wr_ptr - rd_ptr;

    // Fetch when the array has data and the holding register is empty or draining
    assign load = (ram_cnt != '0) && (!out_valid || out_ready);

    // Held beat counts too, so capacity stays 2^SIZE
    assign fill     = CNT_W'(ram_cnt) + CNT_W'(out_valid);
    assign in_ready = (fill < CNT_W'(DEPTH));

    // RAM write port
    always_ff @(posedge clk)
    begin
        if (push)
        begin
            mem[wr_ptr[SIZE-1:0]] <= in_beat;
        end
    end

    // RAM read port, registered into the holding register
    always_ff @(posedge clk)
    begin
        if (load)
        begin
            out_beat <= mem[rd_ptr[SIZE-1:0]];
        end
    end

    // --------------------
    // Pointer and valid control
    // --------------------
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            out_valid <= 1'b0;
        end
        else
        begin
            if (push)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (load)
            begin
                rd_ptr    <= rd_ptr + 1'b1;
                out_valid <= 1'b1;
            end
            else if (out_ready)
            begin
                // Held beat taken with nothing behind it
                out_valid <= 1'b0;
            end
        end
    end

    // Counts from registered pointers only
    assign status.occupied = fill;
    assign status.space    = CNT_W'(DEPTH) - fill;

endmodule

/* verilog/axis_fifo.sv */
// Size-selecting stream FIFO wrapper, builds one FIFO body chosen by SIZE
`timescale 1ns/1ps

module axis_fifo #(
    // Capacity is 2^SIZE beats, or 2 beats for SIZE 1 and 2
    parameter int SIZE = 5
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  axis_stream_pkg::axis_beat_t in_beat,
    input  logic                        in_valid,
    output logic                        in_ready,
    output axis_stream_pkg::axis_beat_t out_beat,
    output logic                        out_valid,
    input  logic                        out_ready,
    output fifo_cfg_pkg::fifo_status_t  status
);
    import fifo_cfg_pkg::*;

    // SIZE 1..2 registers, 3..5 shift array, above 5 RAM
    localparam fifo_impl_e IMPL = fifo_impl_e'((SIZE <= 2) ? IMPL_MINIMAL :
                                               (SIZE <= 5) ? IMPL_SRL : IMPL_RAM);

    // --------------------
    // Implementation select
    // --------------------
    // Every body reports counts already widened to MAX_SIZE+1 bits
    generate
        case (IMPL)
            IMPL_MINIMAL:
            begin : gen_minimal
                // Two-entry skid-style stage
                axis_minimal_fifo fifo_inst (
                    .clk(clk), .rst_n(rst_n),
                    .in_beat(in_beat), .in_valid(in_valid), .in_ready(in_ready),
                    .out_beat(out_beat), .out_valid(out_valid), .out_ready(out_ready),
                    .status(status)
                );
            end
            IMPL_SRL:
            begin : gen_srl
                // 32-entry shift array cut down to 2^SIZE
                axis_fifo_srl #(.SIZE(SIZE)) fifo_inst (
                    .clk(clk), .rst_n(rst_n),
                    .in_beat(in_beat), .in_valid(in_valid), .in_ready(in_ready),
                    .out_beat(out_beat), .out_valid(out_valid), .out_ready(out_ready),
                    .status(status)
                );
            end
            default:
            begin : gen_ram
                // RAM array, 2 cycles from empty
                axis_fifo_ram #(.SIZE(SIZE)) fifo_inst (
                    .clk(clk), .rst_n(rst_n),
                    .in_beat(in_beat), .in_valid(in_valid), .in_ready(in_ready),
                    .out_beat(out_beat), .out_valid(out_valid), .out_ready(out_ready),
                    .status(status)
                );
            end
        endcase
    endgenerate

endmodule

/* verilog/axis_buffer_chain.sv */
// Stream buffering top level, three FIFO stages in series with gathered status
`timescale 1ns/1ps

module axis_buffer_chain #(
    parameter int SIZE_A = 1,
    parameter int SIZE_B = 5,
    parameter int SIZE_C = 6
) (
    input  logic                        clk,
    input  logic                        rst_n,
    // Upstream
    input  axis_stream_pkg::axis_beat_t in_beat,
    input  logic                        in_valid,
    output logic                        in_ready,
    // Downstream
    output axis_stream_pkg::axis_beat_t out_beat,
    output logic                        out_valid,
    input  logic                        out_ready,
    // Per-stage counts
    output fifo_cfg_pkg::chain_status_t status
);
    import axis_stream_pkg::*;
    import fifo_cfg_pkg::*;

    // --------------------
    // Inter-stage links
    // --------------------
    // Stage A to stage B
    axis_beat_t   ab_beat;
    logic         ab_valid;
    logic         ab_ready;
    // Stage B to stage C
    axis_beat_t   bc_beat;
    logic         bc_valid;
    logic         bc_ready;
    fifo_status_t status_a;
    fifo_status_t status_b;
    fifo_status_t status_c;

    // Input stage, register FIFO
    axis_fifo #(.SIZE(SIZE_A)) stage_a_inst (
        .clk(clk), .rst_n(rst_n),
        .in_beat(in_beat), .in_valid(in_valid), .in_ready(in_ready),
        .out_beat(ab_beat), .out_valid(ab_valid), .out_ready(ab_ready),
        .status(status_a)
    );

    // Middle stage, shift-register FIFO
    axis_fifo #(.SIZE(SIZE_B)) stage_b_inst (
        .clk(clk), .rst_n(rst_n),
        .in_beat(ab_beat), .in_valid(ab_valid), .in_ready(ab_ready),
        .out_beat(bc_beat), .out_valid(bc_valid), .out_ready(bc_ready),
        .status(status_b)
    );

    // Output stage, RAM FIFO
    axis_fifo #(.SIZE(SIZE_C)) stage_c_inst (
        .clk(clk), .rst_n(rst_n),
        .in_beat(bc_beat), .in_valid(bc_valid), .in_ready(bc_ready),
        .out_beat(out_beat), .out_valid(out_valid), .out_ready(out_ready),
        .status(status_c)
    );

    assign status = '{stage_a: status_a, stage_b: status_b, stage_c: status_c};

endmodule

/* test/axis_checker.sv */
// Checker for the buffer chain, keeps the model queue from the DUT ports and the test counts
`timescale 1ns/1ps

module axis_checker (
    input  logic                        clk,
    input  logic                        rst_n,
    input  axis_stream_pkg::axis_beat_t in_beat,
    input  logic                        in_valid,
    input  logic                        in_ready,
    input  axis_stream_pkg::axis_beat_t out_beat,
    input  logic                        out_valid,
    input  logic                        out_ready,
    input  fifo_cfg_pkg::chain_status_t status
);
    import axis_stream_pkg::*;
    import fifo_cfg_pkg::*;

    // Stage capacities: two registers, 2^5 shift array, 2^6 RAM
    localparam int CAP_A = 2;
    localparam int CAP_B = 32;
    localparam int CAP_C = 64;

    // Beats accepted by the chain and not yet delivered
    axis_beat_t model_q[$];
    axis_beat_t head_beat;
    string      cur_test;
    int         test_errs   = 0;
    // Errors from the per-cycle status watch
    int         status_errs = 0;
    int         out_count   = 0;
    int         pass_cnt    = 0;
    int         fail_cnt    = 0;
    int         occ_sum;

    // --------------------
    // Test bookkeeping
    // --------------------
    task start_test(input string name);
        cur_test  = name;
        test_errs = 0;
    endtask

    task check_eq(input string what, input longint expected, input longint actual);
        if (expected != actual)
        begin
            $display("FAIL %s %s expected %0h actual %0h", cur_test, what, expected, actual);
            test_errs++;
        end
    endtask

    task report_error(input string msg);
        $display("ERROR in %s: %s", cur_test, msg);
        test_errs++;
    endtask

    task finish_test(input string name, input int errs);
        if (errs == 0)
        begin
            $display("PASS %s", name);
            pass_cnt++;
        end
        else
        begin
            $display("%s finished with %0d errors", name, errs);
            fail_cnt++;
        end
    endtask

    // Occupied as given, space is the rest of each capacity
    task check_levels(input int occ_a, input int occ_b, input int occ_c);
        check_eq("occupied_a", occ_a, status.stage_a.occupied);
        check_eq("occupied_b", occ_b, status.stage_b.occupied);
        check_eq("occupied_c", occ_c, status.stage_c.occupied);
        check_eq("space_a", CAP_A - occ_a, status.stage_a.space);
        check_eq("space_b", CAP_B - occ_b, status.stage_b.space);
        check_eq("space_c", CAP_C - occ_c, status.stage_c.space);
    endtask

    // Empty chain, as after reset
    task check_idle();
        check_eq("out_valid", 0, out_valid);
        check_eq("in_ready", 1, in_ready);
        check_levels(0, 0, 0);
    endtask

    // Blocked output presents the oldest accepted beat
    task check_held();
        check_eq("out_valid", 1, out_valid);
        if (model_q.size() == 0)
        begin
            report_error("no beat was held at the output while it was blocked");
        end
        else
        begin
            check_eq("held_tdata", model_q[0].tdata, out_beat.tdata);
            check_eq("held_tlast", model_q[0].tlast, out_beat.tlast);
        end
    endtask

    task print_counts();
        $display("Tests run: %0d, passed: %0d, failed: %0d",
                 pass_cnt + fail_cnt, pass_cnt, fail_cnt);
    endtask

    // --------------------
    // Output beat compare
    // --------------------
    // Pop before push, a beat never leaves on the edge it enters
    always @(posedge clk)
    begin
        if (rst_n && out_valid && out_ready)
        begin
            out_count++;
            if (model_q.size() == 0)
            begin
                report_error("a beat came out that was never accepted");
            end
            else
            begin
                head_beat = model_q.pop_front();
                check_eq("tdata", head_beat.tdata, out_beat.tdata);
                check_eq("tlast", head_beat.tlast, out_beat.tlast);
            end
        end
        if (rst_n && in_valid && in_ready)
        begin
            model_q.push_back(in_beat);
        end
    end

    // --------------------
    // Status watch
    // --------------------
    // Mid-cycle, after both queue ends have moved
    always @(negedge clk)
    begin
        if (rst_n)
        begin
            if (int'(status.stage_a.space) + int'(status.stage_a.occupied) != CAP_A)
            begin
                $display("FAIL status_consistency stage_a expected %0d actual %0d", CAP_A,
                         int'(status.stage_a.space) + int'(status.stage_a.occupied));
                status_errs++;
            end
            if (int'(status.stage_b.space) + int'(status.stage_b.occupied) != CAP_B)
            begin
                $display("FAIL status_consistency stage_b expected %0d actual %0d", CAP_B,
                         int'(status.stage_b.space) + int'(status.stage_b.occupied));
                status_errs++;
            end
            if (int'(status.stage_c.space) + int'(status.stage_c.occupied) != CAP_C)
            begin
                $display("FAIL status_consistency stage_c expected %0d actual %0d", CAP_C,
                         int'(status.stage_c.space) + int'(status.stage_c.occupied));
                status_errs++;
            end
            // Beats in flight must match the model depth
            occ_sum = int'(status.stage_a.occupied) + int'(status.stage_b.occupied)
                    + int'(status.stage_c.occupied);
            if (occ_sum != model_q.size())
            begin
                $display("FAIL status_consistency occupied_sum expected %0d actual %0d",
                         model_q.size(), occ_sum);
                status_errs++;
            end
        end
    end

endmodule

/* test/tb_top.sv */
// Testbench top for the buffer chain: clock, reset, random stimulus and the test sequence
`timescale 1ns/1ps

module tb_top;
    import axis_stream_pkg::*;
    import fifo_cfg_pkg::*;

    localparam int NUM_BEATS  = 300;
    // 2 + 32 + 64 beats
    localparam int CHAIN_CAP  = 98;
    localparam int WAIT_LIMIT = 5000;
    // Cycles of steady low in_ready that count as full
    localparam int LOW_STEADY = 8;

    logic          clk;
    logic          rst_n;
    axis_beat_t    in_beat;
    logic          in_valid;
    logic          in_ready;
    axis_beat_t    out_beat;
    logic          out_valid;
    logic          out_ready;
    chain_status_t status;
    int            accepted_cnt;
    int            offered;
    int            cycles;
    int            low_run;
    int            start_acc;
    int            start_out;

    // 100 ns period
    always #50 clk = ~clk;

    axis_buffer_chain axis_buffer_chain_inst (
        .clk(clk), .rst_n(rst_n),
        .in_beat(in_beat), .in_valid(in_valid), .in_ready(in_ready),
        .out_beat(out_beat), .out_valid(out_valid), .out_ready(out_ready),
        .status(status)
    );

    axis_checker checker_inst (
        .clk(clk), .rst_n(rst_n),
        .in_beat(in_beat), .in_valid(in_valid), .in_ready(in_ready),
        .out_beat(out_beat), .out_valid(out_valid), .out_ready(out_ready),
        .status(status)
    );

    // Accepted input beats, paces the offers
    always @(posedge clk)
    begin
        if (rst_n && in_valid && in_ready)
        begin
            accepted_cnt++;
        end
    end

    function automatic axis_beat_t random_beat();
        axis_beat_t beat;
        beat.tdata = $urandom;
        beat.tlast = 1'($urandom_range(1, 0));
        return beat;
    endfunction

    // Stop input, open the output, wait until every accepted beat is out
    task automatic drain_chain();
        int waited;
        waited = 0;
        @(negedge clk);
        in_valid  = 1'b0;
        out_ready = 1'b1;
        while ((checker_inst.out_count != accepted_cnt || out_valid) && waited < WAIT_LIMIT)
        begin
            @(negedge clk);
            waited++;
        end
        if (waited >= WAIT_LIMIT)
            checker_inst.report_error("timed out waiting for the chain to drain");
    endtask

    // --------------------
    // Test sequence
    // --------------------
    initial
    begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        in_beat      = '0;
        in_valid     = 1'b0;
        out_ready    = 1'b0;
        accepted_cnt = 0;
        void'($urandom(32'hbb21e9c2));
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        checker_inst.start_test("reset_state");
        @(negedge clk);
        checker_inst.check_idle();
        checker_inst.finish_test("reset_state", checker_inst.test_errs);

        // Random valid and ready duty cycles
        checker_inst.start_test("ordered_delivery");
        start_out = checker_inst.out_count;
        offered   = accepted_cnt;
        cycles    = 0;
        while (accepted_cnt < NUM_BEATS && cycles < WAIT_LIMIT)
        begin
            @(negedge clk);
            cycles++;
            out_ready = ($urandom_range(99, 0) < 60);
            // A beat still waiting keeps valid and payload
            if (!(in_valid && accepted_cnt < offered))
            begin
                in_valid = 1'b0;
                if (offered < NUM_BEATS && $urandom_range(99, 0) < 70)
                begin
                    in_beat  = random_beat();
                    in_valid = 1'b1;
                    offered++;
                end
            end
        end
        if (accepted_cnt < NUM_BEATS)
            checker_inst.report_error("timed out before all random beats were accepted");
        drain_chain();
        checker_inst.check_eq("delivered", NUM_BEATS, checker_inst.out_count - start_out);
        checker_inst.check_idle();
        checker_inst.finish_test("ordered_delivery", checker_inst.test_errs);

        // Output blocked, input always offered
        checker_inst.start_test("fill_backpressure");
        start_acc = accepted_cnt;
        low_run   = 0;
        cycles    = 0;
        while (low_run < LOW_STEADY && cycles < WAIT_LIMIT)
        begin
            @(negedge clk);
            cycles++;
            out_ready = 1'b0;
            // in_ready only moves on the rising edge, so an offer now is taken
            in_valid = in_ready;
            if (in_ready)
            begin
                in_beat = random_beat();
                low_run = 0;
            end
            else
            begin
                low_run++;
            end
        end
        if (low_run < LOW_STEADY)
            checker_inst.report_error("in_ready never stayed low while filling");
        checker_inst.check_eq("accepted", CHAIN_CAP, accepted_cnt - start_acc);
        checker_inst.check_held();
        checker_inst.check_levels(2, 32, 64);
        checker_inst.finish_test("fill_backpressure", checker_inst.test_errs);

        checker_inst.start_test("drain_recovery");
        start_out = checker_inst.out_count;
        drain_chain();
        checker_inst.check_eq("delivered", CHAIN_CAP, checker_inst.out_count - start_out);
        checker_inst.check_idle();
        checker_inst.finish_test("drain_recovery", checker_inst.test_errs);

        // Checked every cycle since reset
        checker_inst.finish_test("status_consistency", checker_inst.status_errs);

        checker_inst.print_counts();
        if (checker_inst.fail_cnt == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

/* filelist.f */
verilog/axis_stream_pkg.sv
verilog/fifo_cfg_pkg.sv
verilog/axis_minimal_fifo.sv
verilog/axis_fifo_srl.sv
verilog/axis_fifo_ram.sv
verilog/axis_fifo.sv
verilog/axis_buffer_chain.sv
test/axis_checker.sv
test/tb_top.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the buffer chain testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_top -f filelist.f
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

sim_output=$(./obj_dir/Vtb_top)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_output" | grep -qF "All tests passed!"; then
    exit 0
else
    echo "Simulation did not report a pass"
    exit 1
fi
